// File: all.f
+incdir+logic
logic/daq_tx_pkg.sv
logic/frame_ctrl_if.sv
logic/daq_frame_fsm.sv
logic/word_timer.sv
logic/ordered_set_rom.sv
logic/crc32_word_gen.sv
logic/tx_word_mux.sv
logic/daq_optical_tx.sv
dv/tb_clk_gen.sv
dv/daq_tx_properties.sv
dv/tb_daq_optical_tx.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = tb_daq_optical_tx
FLIST     = all.f
OBJ_DIR   = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

# Build, run, then look for the pass line in the captured output
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_daq_optical_tx.sv
`timescale 1ns/1ps
`include "daq_tx_defines.svh"

module tb_daq_optical_tx import daq_tx_pkg::*; ();

	localparam int clk_period = 20;

	// Line words from the ordered-set table
	localparam tx_word_t w_idle     = {16'h50BC, 2'b01};
	localparam tx_word_t w_sop_pre  = {16'h55FB, 2'b01};
	localparam tx_word_t w_preamble = {16'h5555, 2'b00};
	localparam tx_word_t w_sof_pre  = {16'hD555, 2'b00};
	localparam tx_word_t w_eop      = {16'hF7FD, 2'b11};
	localparam tx_word_t w_car_ext  = {16'hF7F7, 2'b11};

	localparam logic [15:0] junk_data = 16'hDEAD;   // Offered before the ack
	localparam tx_word_t    w_junk    = {junk_data, 2'b00};

	localparam int payload_words = 1 + 8 + 4 + 5 + 6;
	localparam int packet_count  = 5;
	localparam int wd_cycles     = 40 + payload_words
		+ packet_count * (9 + `DAQ_IPG_WORDS + 30) + 200;

	logic        usr_clk_wordwise;
	logic        arst;
	logic [15:0] txd_i;
	logic        txd_vld_i;
	tx_word_t    tx_word_o;
	logic        tx_ack_o;

	tx_word_t mon_q[$];       // Every word seen after reset
	tx_word_t exp_q[$];       // Expected frame words of the running test
	int       frame_len[$];
	int       mon_base;
	int       errors;
	int       err_at_start;
	int       tests_run;
	int       seed;

	tb_clk_gen u_tb_clk_gen (
		.clk_o  (usr_clk_wordwise),
		.arst_o (arst)
	);

	daq_optical_tx u_daq_optical_tx (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.txd_i            (txd_i),
		.txd_vld_i        (txd_vld_i),
		.tx_word_o        (tx_word_o),
		.tx_ack_o         (tx_ack_o)
	);

	bind daq_optical_tx daq_tx_properties u_daq_tx_properties (.*);

	always @(negedge usr_clk_wordwise)
	begin
		if (!arst)
			mon_q.push_back(tx_word_o);         // Stable half a cycle after the edge
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks and reference model
	////////////////////////////////////////////////////////////////////////////

	task automatic compare_word(input tx_word_t act, input tx_word_t exp, input string what);
		if (act !== exp)
		begin
			$display("error @ %0t ns: %s got %h/%b, expected %h/%b",
				$time, what, act.data, act.k, exp.data, exp.k);
			errors++;
		end
	endtask

	task automatic compare_bit(input logic act, input logic exp, input string what);
		if (act !== exp)
		begin
			$display("error @ %0t ns: %s got %b, expected %b", $time, what, act, exp);
			errors++;
		end
	endtask

	// Ethernet CRC-32 a byte at a time with the low byte of each word first
	function automatic logic [31:0] crc32_ref(input logic [15:0] words[$]);
		logic [31:0] crc;
		logic [7:0]  b;
		int          half;
		crc = 32'hFFFFFFFF;
		foreach (words[n])
		begin
			for (half = 0; half < 2; half++)
			begin
				b   = (half == 0) ? words[n][7:0] : words[n][15:8];
				crc = crc ^ {24'd0, b};
				repeat (8)
					crc = crc[0] ? ((crc >> 1) ^ 32'hEDB88320) : (crc >> 1);
			end
		end
		return ~crc;
	endfunction

	task automatic add_frame(input logic [15:0] words[$]);
		logic [31:0] crc;
		crc = crc32_ref(words);
		exp_q.push_back(w_sop_pre);
		repeat (`DAQ_PREAMBLE_WORDS)
			exp_q.push_back(w_preamble);
		exp_q.push_back(w_sof_pre);
		foreach (words[n])
			exp_q.push_back({words[n], 2'b00});
		exp_q.push_back({crc[15:0], 2'b00});    // CRC low half first
		exp_q.push_back({crc[31:16], 2'b00});
		exp_q.push_back(w_eop);
		exp_q.push_back(w_car_ext);
		frame_len.push_back(words.size() + `DAQ_PREAMBLE_WORDS + 6);
	endtask

	function automatic int frames_seen();
		int cnt;
		cnt = 0;
		for (int n = mon_base; n < mon_q.size(); n++)
		begin
			if (mon_q[n] == w_car_ext)
				cnt++;
		end
		return cnt;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Source side and stream checking
	////////////////////////////////////////////////////////////////////////////

	task automatic send_packet(input logic [15:0] words[$]);
		int   idx;
		int   wait_cycles;
		logic acked;
		idx         = 0;
		wait_cycles = 1;                        // Request cycle itself
		acked       = 1'b0;
		@(posedge usr_clk_wordwise);
		#1;
		txd_vld_i = 1'b1;
		txd_i     = junk_data;
		while (idx < words.size())
		begin
			@(posedge usr_clk_wordwise);
			#1;
			if (acked)
				compare_bit(tx_ack_o, 1'b1, "tx_ack_o during packet");
			if (tx_ack_o)
			begin
				if (!acked && wait_cycles < 5)
				begin
					$display("tx_ack_o rose %0d cycles after the request, too early",
						wait_cycles);
					errors++;
				end
				acked = 1'b1;
				txd_i = words[idx];             // Taken at the next edge
				idx++;
			end
			else
			begin
				txd_i = junk_data;
				wait_cycles++;
				if (wait_cycles > 40)
				begin
					$display("packet stalled, tx_ack_o stayed low for 40 cycles");
					errors++;
					break;
				end
			end
		end
		@(posedge usr_clk_wordwise);
		#1;
		txd_vld_i = 1'b0;
		txd_i     = '0;
	endtask

	task automatic wait_frames(input int count);
		int cycles;
		cycles = 0;
		while (frames_seen() < count && cycles < 100)
		begin
			@(posedge usr_clk_wordwise);
			cycles++;
		end
		if (frames_seen() < count)
		begin
			$display("only %0d of %0d frames appeared on tx_word_o", frames_seen(), count);
			errors++;
		end
		repeat (`DAQ_IPG_WORDS + 4)
			@(posedge usr_clk_wordwise);       // Let the gap and trailing idles pass
	endtask

	task automatic check_stream();
		int pos;
		int e;
		int i;
		int idles;
		pos = mon_base;
		e   = 0;
		foreach (frame_len[f])
		begin
			idles = 0;
			while (pos < mon_q.size() && mon_q[pos] == w_idle)
			begin
				idles++;
				pos++;
			end
			if (f == 0 && idles < 1)
			begin
				$display("no idle word before the first frame");
				errors++;
			end
			else if (f > 0 && idles < `DAQ_IPG_WORDS)
			begin
				$display("only %0d idle words between frame %0d and %0d", idles, f - 1, f);
				errors++;
			end
			for (i = 0; i < frame_len[f]; i++)
			begin
				if (pos >= mon_q.size())
				begin
					$display("output stream ended inside frame %0d", f);
					errors++;
					break;
				end
				compare_word(mon_q[pos], exp_q[e], $sformatf("frame %0d word %0d", f, i));
				pos++;
				e++;
			end
		end
		idles = 0;
		while (pos < mon_q.size() && mon_q[pos] == w_idle)
		begin
			idles++;
			pos++;
		end
		if (idles < 1 || pos != mon_q.size())
		begin
			$display("output after the last frame is not all idle");
			errors++;
		end
	endtask

	task automatic begin_test();
		@(posedge usr_clk_wordwise);
		#1;
		mon_base = mon_q.size();
		exp_q.delete();
		frame_len.delete();
		err_at_start = errors;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == err_at_start)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - err_at_start);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_idle_after_reset();
		begin_test();
		repeat (20)
		begin
			@(negedge usr_clk_wordwise);
			compare_word(tx_word_o, w_idle, "idle line");
			compare_bit(tx_ack_o, 1'b0, "tx_ack_o without request");
		end
		end_test("test 1 idle after reset");
	endtask

	task automatic test_single_word();
		logic [15:0] words[$];
		words.push_back(16'hA5C3);
		begin_test();
		add_frame(words);
		send_packet(words);
		wait_frames(1);
		check_stream();
		end_test("test 2 one word packet");
	endtask

	task automatic test_random_payload();
		logic [15:0] words[$];
		repeat (8)
			words.push_back(16'($random(seed)));
		begin_test();
		add_frame(words);
		send_packet(words);
		wait_frames(1);
		check_stream();
		end_test("test 3 eight random words");
	endtask

	task automatic test_early_words();
		logic [15:0] words[$];
		int          leaks;
		int          legit;
		words = '{16'h0001, 16'h0002, 16'h0003, 16'h0004};
		leaks = 0;
		legit = 0;
		begin_test();
		add_frame(words);
		send_packet(words);
		wait_frames(1);
		check_stream();
		for (int n = mon_base; n < mon_q.size(); n++)
		begin
			if (mon_q[n] == w_junk)
				leaks++;
		end
		foreach (exp_q[n])
		begin
			if (exp_q[n] == w_junk)
				legit++;                        // A CRC half could match by chance
		end
		if (leaks != legit)
		begin
			$display("word offered before tx_ack_o appeared on the line");
			errors++;
		end
		end_test("test 4 early words dropped");
	endtask

	task automatic test_back_to_back();
		logic [15:0] first[$];
		logic [15:0] second[$];
		repeat (5)
			first.push_back(16'($random(seed)));
		repeat (6)
			second.push_back(16'($random(seed)));
		begin_test();
		add_frame(first);
		add_frame(second);
		send_packet(first);
		send_packet(second);                    // Request again right after the drop
		wait_frames(2);
		check_stream();
		end_test("test 5 back to back packets");
	endtask

	initial
	begin
		txd_i        = '0;
		txd_vld_i    = 1'b0;
		errors       = 0;
		err_at_start = 0;
		tests_run    = 0;
		mon_base     = 0;
		seed         = 59657;
		@(negedge arst);
		test_idle_after_reset();
		test_single_word();
		test_random_payload();
		test_early_words();
		test_back_to_back();
		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// Watchdog sized from the packet lengths
	initial
	begin
		#(wd_cycles * clk_period);
		$display("watchdog expired after %0d cycles, the run did not finish", wd_cycles);
		$display(">>> FAIL");
		$finish;
	end

endmodule

// File: dv/daq_tx_properties.sv
`timescale 1ns/1ps

module daq_tx_properties import daq_tx_pkg::*; (
	input logic     usr_clk_wordwise,
	input logic     arst,
	input logic     txd_vld_i,
	input logic     tx_ack_o,
	input tx_word_t tx_word_o
);

	// First cycle out of reset
	ack_low_after_reset: assert property (
		@(posedge usr_clk_wordwise) $fell(arst) |-> !tx_ack_o
	) else $error("tx_ack_o high in the first cycle after reset");

	// Ack comes at least 5 cycles into a held request
	ack_needs_request: assert property (
		@(posedge usr_clk_wordwise) disable iff (arst)
		$rose(tx_ack_o) |-> txd_vld_i && $past(txd_vld_i, 5)
	) else $error("tx_ack_o rose without a request held for 5 cycles");

	// Only EOP and carrier extend carry two K characters
	double_k_is_end: assert property (
		@(posedge usr_clk_wordwise) disable iff (arst)
		(tx_word_o.k == 2'b11) |-> (tx_word_o.data inside {16'hF7FD, 16'hF7F7})
	) else $error("word with both K-flags is neither EOP nor carrier extend");

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk_o,
	output logic arst_o
);

	localparam int half_period = 10;    // 20 ns clock

	initial
	begin
		clk_o = 1'b0;
		forever
			#half_period clk_o = ~clk_o;
	end

	// Reset held for 5 rising edges and released just after the last one
	initial
	begin
		arst_o = 1'b1;
		repeat (5)
			@(posedge clk_o);
		#1;
		arst_o = 1'b0;
	end

endmodule

// File: logic/daq_optical_tx.sv
`timescale 1ns/1ps
`include "daq_tx_defines.svh"

module daq_optical_tx import daq_tx_pkg::*; (
	input  logic                   usr_clk_wordwise,
	input  logic                   arst,
	input  logic [`DAQ_WORD_W-1:0] txd_i,
	input  logic                   txd_vld_i,
	output tx_word_t               tx_word_o,
	output logic                   tx_ack_o
);

	frame_ctrl_if ctrl_if ();

	logic        timer_load;
	logic [3:0]  timer_value;
	logic        timer_zero;
	tx_word_t    set_word;
	logic [31:0] crc;

	daq_frame_fsm u_daq_frame_fsm (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.txd_vld_i        (txd_vld_i),
		.timer_zero_i     (timer_zero),
		.tx_ack_o         (tx_ack_o),
		.timer_load_o     (timer_load),
		.timer_value_o    (timer_value),
		.ctrl             (ctrl_if.fsm)
	);

	// Preamble and gap lengths
	word_timer u_word_timer (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.load_i           (timer_load),
		.value_i          (timer_value),
		.zero_o           (timer_zero)
	);

	ordered_set_rom u_ordered_set_rom (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.ctrl             (ctrl_if.dp),
		.set_o            (set_word)
	);

	crc32_word_gen u_crc32_word_gen (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.d_i              (txd_i),
		.ctrl             (ctrl_if.dp),
		.crc_o            (crc)
	);

	tx_word_mux u_tx_word_mux (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.txd_i            (txd_i),
		.set_i            (set_word),
		.crc_i            (crc),
		.ctrl             (ctrl_if.dp),
		.tx_word_o        (tx_word_o)
	);

endmodule

// File: logic/tx_word_mux.sv
`timescale 1ns/1ps
`include "daq_tx_defines.svh"

module tx_word_mux import daq_tx_pkg::*; (
	input  logic                   usr_clk_wordwise,
	input  logic                   arst,
	input  logic [`DAQ_WORD_W-1:0] txd_i,
	input  tx_word_t               set_i,
	input  logic [31:0]            crc_i,
	frame_ctrl_if.dp               ctrl,
	output tx_word_t               tx_word_o
);

	localparam tx_word_t idle_word = {`D16_2, `K28_5, `K_LO};

	word_src_t              src_q;
	logic [`DAQ_WORD_W-1:0] data_q;

	// One stage to line up with the ROM register
	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			src_q <= OS;
		else
			src_q <= ctrl.word_src;
	end

	always_ff @(posedge usr_clk_wordwise)
	begin
		data_q <= txd_i;                          // Payload delay
	end

	////////////////////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			tx_word_o <= idle_word;
		else
		begin
			case (src_q)
				OS:      tx_word_o <= set_i;
				DATA:    tx_word_o <= {data_q, `K_NONE};
				CRC_LO:  tx_word_o <= {crc_i[15:0], `K_NONE};   // Low half goes first
				CRC_HI:  tx_word_o <= {crc_i[31:16], `K_NONE};
				default: tx_word_o <= idle_word;
			endcase
		end
	end

endmodule

// File: logic/crc32_word_gen.sv
`timescale 1ns/1ps
`include "daq_tx_defines.svh"

module crc32_word_gen (
	input  logic                   usr_clk_wordwise,
	input  logic                   arst,
	input  logic [`DAQ_WORD_W-1:0] d_i,
	frame_ctrl_if.dp               ctrl,
	output logic [31:0]            crc_o
);

	localparam logic [31:0] crc_poly = 32'hEDB88320;   // 04C11DB7 bit reversed

	logic [31:0] crc_q;

	////////////////////////////////////////////////////////////////////////////
	// Reflected CRC with bit 0 of the low byte first
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] crc_fold(
		input logic [31:0]            crc,
		input logic [`DAQ_WORD_W-1:0] d
	);
		logic [31:0] c;
		int          i;
		c = crc;
		for (i = 0; i < `DAQ_WORD_W; i++)
		begin
			if (c[0] ^ d[i])
				c = (c >> 1) ^ crc_poly;
			else
				c = c >> 1;
		end
		return c;
	endfunction

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			crc_q <= '1;
		else if (ctrl.crc_clear)
			crc_q <= '1;                          // Preset for a new frame
		else if (ctrl.crc_enable)
			crc_q <= crc_fold(crc_q, d_i);
	end

	assign crc_o = ~crc_q;

endmodule

// File: logic/ordered_set_rom.sv
`timescale 1ns/1ps
`include "daq_tx_defines.svh"

module ordered_set_rom import daq_tx_pkg::*; (
	input  logic      usr_clk_wordwise,
	input  logic      arst,
	frame_ctrl_if.dp  ctrl,
	output tx_word_t  set_o
);

	localparam tx_word_t idle_word = {`D16_2, `K28_5, `K_LO};

	// Set words with the high byte on the left
	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			set_o <= idle_word;
		else
		begin
			case (ctrl.os_sel)
				IDLE:     set_o <= idle_word;
				SOP_PRE:  set_o <= {`PRMBL, `K27_7, `K_LO};       // SOP plus first preamble
				PREAMBLE: set_o <= {`PRMBL, `PRMBL, `K_NONE};
				SOF_PRE:  set_o <= {`SOF_BYTE, `PRMBL, `K_NONE};
				EOP:      set_o <= {`K23_7, `K29_7, `K_BOTH};     // EOP plus carrier extend
				CAR_EXT:  set_o <= {`K23_7, `K23_7, `K_BOTH};
				default:  set_o <= idle_word;
			endcase
		end
	end

endmodule

// File: logic/word_timer.sv
`timescale 1ns/1ps

module word_timer (
	input  logic       usr_clk_wordwise,
	input  logic       arst,
	input  logic       load_i,
	input  logic [3:0] value_i,
	output logic       zero_o
);

	logic [3:0] count;

	// Load wins over the decrement
	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
		begin
			count <= 4'd0;
		end
		else if (load_i)
		begin
			count <= value_i;
		end
		else if (count != 4'd0)
		begin
			count <= count - 4'd1;    // Holds at zero
		end
	end

	assign zero_o = (count == 4'd0);

endmodule

// File: logic/daq_frame_fsm.sv
`timescale 1ns/1ps
`include "daq_tx_defines.svh"

module daq_frame_fsm import daq_tx_pkg::*; (
	input  logic       usr_clk_wordwise,
	input  logic       arst,
	input  logic       txd_vld_i,
	input  logic       timer_zero_i,
	output logic       tx_ack_o,
	output logic       timer_load_o,
	output logic [3:0] timer_value_o,
	frame_ctrl_if.fsm  ctrl
);

	typedef enum logic [3:0] {
		S_IDLE,
		S_SOP,
		S_PRE,
		S_SOF,
		S_DATA,     // Last cycle here sends the low CRC half
		S_CRC_HI,
		S_EOP,
		S_CEXT,
		S_GAP
	} state_t;

	state_t state;
	state_t state_nxt;

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			state <= S_IDLE;
		else
			state <= state_nxt;
	end

	////////////////////////////////////////////////////////////////////////////
	// Next state and per-cycle selects
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		state_nxt       = state;
		ctrl.os_sel     = IDLE;
		ctrl.word_src   = OS;
		ctrl.crc_clear  = 1'b0;
		ctrl.crc_enable = 1'b0;
		tx_ack_o        = 1'b0;
		timer_load_o    = 1'b0;
		timer_value_o   = 4'(`DAQ_IPG_WORDS - 1);
		case (state)
			S_IDLE:
			begin
				if (txd_vld_i)
					state_nxt = S_SOP;
			end
			S_SOP:
			begin
				ctrl.os_sel   = SOP_PRE;
				timer_load_o  = 1'b1;                            // Time the preamble
				timer_value_o = 4'(`DAQ_PREAMBLE_WORDS - 1);
				state_nxt     = S_PRE;
			end
			S_PRE:
			begin
				ctrl.os_sel = PREAMBLE;
				if (timer_zero_i)
					state_nxt = S_SOF;
			end
			S_SOF:
			begin
				ctrl.os_sel    = SOF_PRE;
				ctrl.crc_clear = 1'b1;
				state_nxt      = S_DATA;
			end
			S_DATA:
			begin
				if (txd_vld_i)
				begin
					tx_ack_o        = 1'b1;
					ctrl.word_src   = DATA;
					ctrl.crc_enable = 1'b1;                      // Word taken this cycle
				end
				else
				begin
					ctrl.word_src = CRC_LO;                      // Source let go so the frame closes
					state_nxt     = S_CRC_HI;
				end
			end
			S_CRC_HI:
			begin
				ctrl.word_src = CRC_HI;
				state_nxt     = S_EOP;
			end
			S_EOP:
			begin
				ctrl.os_sel = EOP;
				state_nxt   = S_CEXT;
			end
			S_CEXT:
			begin
				ctrl.os_sel  = CAR_EXT;
				timer_load_o = 1'b1;                             // Start the gap count
				state_nxt    = S_GAP;
			end
			S_GAP:
			begin
				if (timer_zero_i)
					state_nxt = txd_vld_i ? S_SOP : S_IDLE;
			end
			default:
				state_nxt = S_IDLE;
		endcase
	end

endmodule

// File: logic/frame_ctrl_if.sv
`timescale 1ns/1ps

interface frame_ctrl_if import daq_tx_pkg::*; ();

	os_sel_t   os_sel;      // Ordered set to look up
	word_src_t word_src;    // Output word source
	logic      crc_clear;   // Preset CRC before a frame
	logic      crc_enable;  // Fold in the taken word

	modport fsm (
		output os_sel,
		output word_src,
		output crc_clear,
		output crc_enable
	);

	modport dp (
		input  os_sel,
		input  word_src,
		input  crc_clear,
		input  crc_enable
	);

endinterface

// File: logic/daq_tx_pkg.sv
`include "daq_tx_defines.svh"

package daq_tx_pkg;

	// One word towards the transceiver
	typedef struct packed {
		logic [`DAQ_WORD_W-1:0] data;
		logic [1:0]             k;      // Low byte flag in bit 0
	} tx_word_t;

	// Ordered sets held in the ROM
	typedef enum logic [2:0] {
		IDLE,
		SOP_PRE,
		PREAMBLE,
		SOF_PRE,
		EOP,
		CAR_EXT
	} os_sel_t;

	// Which source feeds the output register
	typedef enum logic [1:0] {
		OS,
		DATA,
		CRC_LO,
		CRC_HI
	} word_src_t;

endpackage

// File: logic/daq_tx_defines.svh
`ifndef DAQ_TX_DEFINES_SVH
`define DAQ_TX_DEFINES_SVH

// Line format
`define DAQ_WORD_W          16
`define DAQ_PREAMBLE_WORDS  3   // Plain preamble words after SOP
`define DAQ_IPG_WORDS       6   // Minimum idles between packets

// 8b10b character codes
`define K28_5     8'hBC         // Comma
`define D16_2     8'h50
`define K27_7     8'hFB         // /S/ start of packet
`define K29_7     8'hFD         // /T/ end of packet
`define K23_7     8'hF7         // /R/ carrier extend
`define PRMBL     8'h55         // Preamble octet
`define SOF_BYTE  8'hD5         // Start of frame octet

// Per-word K-flags with bit 0 for the low byte
`define K_NONE    2'b00
`define K_LO      2'b01
`define K_BOTH    2'b11

`endif
